// ==== common/core_pkg.sv ====
`default_nettype none

package core_pkg;

    localparam int XLEN = 32;
    localparam int REG_ADDR_W = 5;
    localparam int QUEUE_DEPTH = 4;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    localparam word_t RESET_PC = '0;

    // major opcodes of the kept instructions
    localparam logic [6:0] OPC_OP = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI = 7'b0110111;
    localparam logic [6:0] OPC_JAL = 7'b1101111;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_t;

    // one fetched instruction with its address
    typedef struct packed {
        word_t pc;
        word_t instr;
    } fetched_t;

    typedef struct packed {
        logic      en;
        reg_addr_t addr;
        word_t     data;
    } reg_write_t;

    // raised by execute for a taken jump
    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_t;

endpackage

`default_nettype wire

// ==== fetch/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import core_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      queue_stall,
    input  redirect_t redirect,
    output logic      instr_req,
    output word_t     instr_addr,
    input  word_t     instr_data,
    input  logic      instr_done,
    output logic      fetch_done,
    output fetched_t  fetched
);

    word_t pc; // next address to fetch
    word_t next_pc;
    logic  busy; // one request outstanding
    logic  drop; // outstanding request is on a flushed path
    logic  start;
    logic  accept;

    always_comb begin
        start = (!busy || instr_done) && !queue_stall; // next request follows the response
        accept = busy && instr_done && !drop;
        if (redirect.valid) begin
            next_pc = redirect.target;
        end else if (accept) begin
            next_pc = pc + word_t'(4);
        end else begin
            next_pc = pc;
        end
        instr_req = busy;
        fetch_done = accept;
        fetched.pc = instr_addr;
        fetched.instr = instr_data;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            pc <= RESET_PC;
            busy <= 1'b0;
            drop <= 1'b0;
        end else begin
            if (start) begin
                busy <= 1'b1;
            end else if (instr_done) begin
                busy <= 1'b0;
            end

            // a response landing with the redirect is thrown away by the flush
            if (instr_done) begin
                drop <= 1'b0;
            end else if (redirect.valid && busy) begin
                drop <= 1'b1;
            end

            pc <= next_pc;
        end
    end

    // address is latched per request so a redirect cannot disturb it
    always_ff @(posedge clk) begin
        if (start) begin
            instr_addr <= next_pc;
        end
    end

    addr_held: assert property (@(posedge clk) disable iff (!rst)
        instr_req && !instr_done |=> instr_req && $stable(instr_addr))
        else $error("instr_addr changed while a request was outstanding");

endmodule

`default_nettype wire

// ==== logic/instruction_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module instruction_queue import core_pkg::*; #(
    parameter int DEPTH = QUEUE_DEPTH
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     fetch_done,
    input  fetched_t fetched,
    input  logic     flush,
    output logic     queue_stall,
    output logic     queue_done,
    output fetched_t head
);

    typedef logic [$clog2(DEPTH)-1:0] ptr_t;
    typedef logic [$clog2(DEPTH+1)-1:0] count_t;

    fetched_t entries [DEPTH];
    ptr_t     rd_ptr;
    ptr_t     wr_ptr;
    count_t   count;
    logic     push;
    logic     pop;

    // wraps at DEPTH, so depths that are not a power of two work too
    function automatic ptr_t next_ptr(input ptr_t ptr);
        return (ptr == ptr_t'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_comb begin
        queue_done = count != '0;
        queue_stall = count == count_t'(DEPTH);
        head = entries[rd_ptr];
        push = fetch_done && !flush; // flush beats a same-cycle push
        pop = queue_done && !flush; // execute takes the head every cycle
    end

    always_ff @(posedge clk) begin
        if (!rst || flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + count_t'(push) - count_t'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= fetched;
        end
    end

    no_push_when_full: assert property (@(posedge clk) disable iff (!rst)
        fetch_done |-> !queue_stall)
        else $error("instruction pushed into a full queue");

endmodule

`default_nettype wire

// ==== logic/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file import core_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  reg_addr_t  rs1,
    input  reg_addr_t  rs2,
    output word_t      rs1_data,
    output word_t      rs2_data,
    input  reg_write_t write
);

    word_t regs [2**REG_ADDR_W];

    // reads see the old value until the write edge
    always_comb begin
        rs1_data = regs[rs1];
        rs2_data = regs[rs2];
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (write.en && write.addr != '0) begin // x0 stays zero
            regs[write.addr] <= write.data;
        end
    end

endmodule

`default_nettype wire

// ==== execute/execute_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_unit import core_pkg::*; (
    input  logic       queue_done,
    input  fetched_t   head,
    output reg_addr_t  rs1,
    output reg_addr_t  rs2,
    input  word_t      rs1_data,
    input  word_t      rs2_data,
    output reg_write_t write,
    output redirect_t  redirect,
    output logic       retire_valid,
    output word_t      retire_pc
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    reg_addr_t  rd;
    word_t      imm_i;
    word_t      imm_j;
    word_t      imm_u;
    alu_op_t    alu_op;
    logic       alu_ok; // funct3 names one of the kept operations
    word_t      operand_b;
    word_t      alu_result;
    logic       is_op;
    logic       is_op_imm;
    logic       is_lui;
    logic       is_jal;

    always_comb begin
        opcode = head.instr[6:0];
        rd = head.instr[11:7];
        funct3 = head.instr[14:12];
        rs1 = head.instr[19:15];
        rs2 = head.instr[24:20];

        imm_i = {{20{head.instr[31]}}, head.instr[31:20]};
        imm_j = {{11{head.instr[31]}}, head.instr[31], head.instr[19:12],
                 head.instr[20], head.instr[30:21], 1'b0};
        imm_u = {head.instr[31:12], 12'b0};

        is_op = opcode == OPC_OP;
        is_op_imm = opcode == OPC_OP_IMM;
        is_lui = opcode == OPC_LUI;
        is_jal = opcode == OPC_JAL;
    end

    // register and immediate forms share the funct3 table
    always_comb begin
        alu_op = ALU_ADD;
        alu_ok = 1'b1;
        case (funct3)
            3'b000: alu_op = (is_op && head.instr[30]) ? ALU_SUB : ALU_ADD; // bit 30 picks sub
            3'b100: alu_op = ALU_XOR;
            3'b110: alu_op = ALU_OR;
            3'b111: alu_op = ALU_AND;
            default: alu_ok = 1'b0;
        endcase
    end

    always_comb begin
        operand_b = is_op ? rs2_data : imm_i;
        case (alu_op)
            ALU_SUB: alu_result = rs1_data - operand_b;
            ALU_AND: alu_result = rs1_data & operand_b;
            ALU_OR:  alu_result = rs1_data | operand_b;
            ALU_XOR: alu_result = rs1_data ^ operand_b;
            default: alu_result = rs1_data + operand_b;
        endcase
    end

    always_comb begin
        retire_valid = queue_done;
        retire_pc = head.pc;

        write.en = queue_done && (is_lui || is_jal || ((is_op || is_op_imm) && alu_ok));
        write.addr = rd;
        if (is_jal) begin
            write.data = head.pc + word_t'(4); // link address
        end else if (is_lui) begin
            write.data = imm_u;
        end else begin
            write.data = alu_result;
        end

        redirect.valid = queue_done && is_jal;
        redirect.target = head.pc + imm_j;
    end

endmodule

`default_nettype wire

// ==== logic/rv32_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv32_core import core_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    output logic       instr_req,
    output word_t      instr_addr,
    input  word_t      instr_data,
    input  logic       instr_done,
    output logic       retire_valid,
    output word_t      retire_pc,
    output reg_write_t retire_write
);

    logic      queue_stall;
    logic      fetch_done;
    fetched_t  fetched;
    logic      queue_done;
    fetched_t  head;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     rs1_data;
    word_t     rs2_data;
    redirect_t redirect;

    fetch_unit fetch (
        .clk ( clk ),
        .rst ( rst ),
        .queue_stall ( queue_stall ),
        .redirect ( redirect ),
        .instr_req ( instr_req ),
        .instr_addr ( instr_addr ),
        .instr_data ( instr_data ),
        .instr_done ( instr_done ),
        .fetch_done ( fetch_done ),
        .fetched ( fetched )
    );

    instruction_queue #(
        .DEPTH ( QUEUE_DEPTH )
    ) queue (
        .clk ( clk ),
        .rst ( rst ),
        .fetch_done ( fetch_done ),
        .fetched ( fetched ),
        .flush ( redirect.valid ), // a jump empties everything fetched after it
        .queue_stall ( queue_stall ),
        .queue_done ( queue_done ),
        .head ( head )
    );

    register_file registers (
        .clk ( clk ),
        .rst ( rst ),
        .rs1 ( rs1 ),
        .rs2 ( rs2 ),
        .rs1_data ( rs1_data ),
        .rs2_data ( rs2_data ),
        .write ( retire_write )
    );

    execute_unit execute (
        .queue_done ( queue_done ),
        .head ( head ),
        .rs1 ( rs1 ),
        .rs2 ( rs2 ),
        .rs1_data ( rs1_data ),
        .rs2_data ( rs2_data ),
        .write ( retire_write ),
        .redirect ( redirect ),
        .retire_valid ( retire_valid ),
        .retire_pc ( retire_pc )
    );

endmodule

`default_nettype wire

// ==== sim/tb_program.svh ====
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// one instruction word per line, the comment gives its byte address and assembly
localparam int PROG_LEN = 26;
localparam logic [31:0] PROG [PROG_LEN] = '{
    32'h00500093, // 00 addi x1, x0, 5
    32'hFFD00113, // 04 addi x2, x0, -3
    32'h002081B3, // 08 add  x3, x1, x2
    32'h40208233, // 0c sub  x4, x1, x2
    32'h0020F2B3, // 10 and  x5, x1, x2
    32'h0020E333, // 14 or   x6, x1, x2
    32'h0020C3B3, // 18 xor  x7, x1, x2
    32'hABCDE437, // 1c lui  x8, 0xabcde
    32'hFFF40413, // 20 addi x8, x8, -1
    32'h80040493, // 24 addi x9, x8, -2048
    32'h80000537, // 28 lui  x10, 0x80000
    32'h00C005EF, // 2c jal  x11, +12
    32'h00100613, // 30 addi x12, x0, 1   skipped
    32'h010006EF, // 34 jal  x13, +16
    32'hFFDFF76F, // 38 jal  x14, -4
    32'h00200613, // 3c addi x12, x0, 2   skipped
    32'h00300613, // 40 addi x12, x0, 3   skipped
    32'h00E587B3, // 44 add  x15, x11, x14
    32'h00700013, // 48 addi x0, x0, 7
    32'h00000833, // 4c add  x16, x0, x0
    32'h0000A883, // 50 lw   x17, 0(x1)   not kept
    32'h01088933, // 54 add  x18, x17, x16
    32'h06408993, // 58 addi x19, x1, 100
    32'h013989B3, // 5c add  x19, x19, x19
    32'h40398A33, // 60 sub  x20, x19, x3
    32'h0000006F  // 64 jal  x0, 0
};

// last pc of each test section
localparam int NUM_TESTS = 5;
localparam logic [31:0] CHECKPOINT [NUM_TESTS] = '{
    32'h00000018,
    32'h00000028,
    32'h00000044,
    32'h00000054,
    32'h00000064
};

`endif

// ==== sim/rv32_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv32_core_tb import core_pkg::*; ();

    `include "tb_program.svh"

    localparam int MAX_RETIRES = 40;
    localparam int TIMEOUT_CYCLES = MAX_RETIRES * 8 + 100; // slowest fetch per instruction
    localparam logic [31:0] SEED = 32'hec1a0e39;
    localparam logic [6:0] JAL_OPCODE = 7'b1101111;

    logic       clk;
    logic       rst;
    logic       instr_req;
    word_t      instr_addr;
    word_t      instr_data = '0;
    logic       instr_done = 1'b0;
    logic       retire_valid;
    word_t      retire_pc;
    reg_write_t retire_write;

    logic [31:0] lcg_state = SEED;
    logic        serving = 1'b0; // memory has seen the current request
    int          wait_left = 0;
    word_t       last_addr;

    word_t      model_pc;
    word_t      model_regs [32];
    word_t      exp_instr;
    word_t      src1;
    word_t      src2;
    reg_write_t exp_write;
    word_t      exp_next_pc;

    int   test_idx = 0;
    int   tests_ok = 0;
    int   check_fails = 0;
    int   fails_at_start;
    int   cycles;
    logic cp_hit;

    rv32_core UUT (
        .clk ( clk ),
        .rst ( rst ),
        .instr_req ( instr_req ),
        .instr_addr ( instr_addr ),
        .instr_data ( instr_data ),
        .instr_done ( instr_done ),
        .retire_valid ( retire_valid ),
        .retire_pc ( retire_pc ),
        .retire_write ( retire_write )
    );

    function automatic logic [31:0] next_random(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic word_t program_word(input word_t addr);
        int idx;
        idx = int'(addr >> 2);
        if (addr < word_t'(PROG_LEN * 4)) begin
            return PROG[idx];
        end
        return {addr[24:0] ^ addr[31:7], 7'b0001011}; // custom-0, never a kept opcode
    endfunction

    function automatic string test_name(input int idx);
        case (idx)
            0: return "register alu ops";
            1: return "addi and lui immediates";
            2: return "jal forward and backward";
            3: return "x0 and unsupported opcode";
            default: return "dependent chain and final jump";
        endcase
    endfunction

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // instruction memory, answers 1 to 5 cycles after it sees a request
    always @(negedge clk) begin
        if (instr_done) begin
            instr_done <= 1'b0;
            serving <= 1'b0;
        end else if (instr_req && !serving) begin
            lcg_state = next_random(lcg_state);
            serving <= 1'b1;
            wait_left <= 1 + int'(lcg_state[20:16]) % 5;
        end else if (serving) begin
            if (wait_left <= 1) begin
                instr_done <= 1'b1;
                instr_data <= program_word(instr_addr);
            end else begin
                wait_left <= wait_left - 1;
            end
        end
    end

    // golden ISA model, evaluated for the instruction at model_pc
    always_comb begin
        exp_instr = program_word(model_pc);
        src1 = model_regs[exp_instr[19:15]];
        src2 = model_regs[exp_instr[24:20]];
        exp_write.en = 1'b0;
        exp_write.addr = exp_instr[11:7];
        exp_write.data = '0;
        exp_next_pc = model_pc + 32'd4;
        case (exp_instr[6:0])
            7'b0110011: begin
                exp_write.en = 1'b1;
                case (exp_instr[14:12])
                    3'b000: exp_write.data = exp_instr[30] ? src1 - src2 : src1 + src2;
                    3'b100: exp_write.data = src1 ^ src2;
                    3'b110: exp_write.data = src1 | src2;
                    3'b111: exp_write.data = src1 & src2;
                    default: exp_write.en = 1'b0;
                endcase
            end
            7'b0010011: begin
                exp_write.en = exp_instr[14:12] == 3'b000;
                exp_write.data = src1 + 32'($signed(exp_instr[31:20]));
            end
            7'b0110111: begin
                exp_write.en = 1'b1;
                exp_write.data = {exp_instr[31:12], 12'h000};
            end
            JAL_OPCODE: begin
                exp_write.en = 1'b1;
                exp_write.data = model_pc + 32'd4;
                exp_next_pc = model_pc + 32'($signed({exp_instr[31], exp_instr[19:12],
                    exp_instr[20], exp_instr[30:21], 1'b0}));
            end
            default: ;
        endcase
    end

    always @(posedge clk) begin
        last_addr <= instr_addr;
        if (!rst) begin
            model_pc <= RESET_PC;
            cp_hit <= 1'b0;
            for (int i = 0; i < 32; i++) begin
                model_regs[i] <= '0;
            end
        end else begin
            cp_hit <= retire_valid && test_idx < NUM_TESTS
                && retire_pc == CHECKPOINT[test_idx];
            if (retire_valid) begin
                model_pc <= exp_next_pc;
                if (exp_write.en && exp_write.addr != 5'd0) begin
                    model_regs[exp_write.addr] <= exp_write.data;
                end
            end
        end
    end

    idle_after_reset: assert property (@(posedge clk)
        !rst |=> !instr_req && !retire_valid && !retire_write.en)
        else begin
            check_fails++;
            $display("request or retire active right after reset");
        end

    pc_in_order: assert property (@(posedge clk) disable iff (!rst)
        retire_valid |-> retire_pc == model_pc)
        else begin
            check_fails++;
            $display("Mismatch retire_pc: got %h expected %h",
                $sampled(retire_pc), $sampled(model_pc));
        end

    write_enable: assert property (@(posedge clk) disable iff (!rst)
        retire_valid |-> retire_write.en == exp_write.en)
        else begin
            check_fails++;
            $display("Mismatch retire_write.en: got %h expected %h",
                $sampled(retire_write.en), $sampled(exp_write.en));
        end

    write_addr: assert property (@(posedge clk) disable iff (!rst)
        retire_valid && exp_write.en |-> retire_write.addr == exp_write.addr)
        else begin
            check_fails++;
            $display("Mismatch retire_write.addr: got %h expected %h",
                $sampled(retire_write.addr), $sampled(exp_write.addr));
        end

    write_data: assert property (@(posedge clk) disable iff (!rst)
        retire_valid && exp_write.en |-> retire_write.data == exp_write.data)
        else begin
            check_fails++;
            $display("Mismatch retire_write.data: got %h expected %h",
                $sampled(retire_write.data), $sampled(exp_write.data));
        end

    no_write_when_idle: assert property (@(posedge clk) disable iff (!rst)
        !retire_valid |-> !retire_write.en)
        else begin
            check_fails++;
            $display("register write without a retiring instruction");
        end

    flush_after_jump: assert property (@(posedge clk) disable iff (!rst)
        retire_valid && exp_instr[6:0] == JAL_OPCODE |=> !retire_valid)
        else begin
            check_fails++;
            $display("instruction retired in the cycle after a jump");
        end

    addr_stable: assert property (@(posedge clk) disable iff (!rst)
        instr_req && !instr_done |=> instr_addr == last_addr)
        else begin
            check_fails++;
            $display("Mismatch instr_addr: got %h expected %h",
                $sampled(instr_addr), $sampled(last_addr));
        end

    initial begin
        rst = 1'b0;
        cycles = 0;
        repeat (4) @(negedge clk);
        rst = 1'b1;
        fails_at_start = check_fails;
        while (test_idx < NUM_TESTS && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
            if (cp_hit) begin
                if (check_fails == fails_at_start) begin
                    tests_ok++;
                    $display("test %0d %s: ok", test_idx + 1, test_name(test_idx));
                end else begin
                    $display("test %0d %s: failed", test_idx + 1, test_name(test_idx));
                end
                fails_at_start = check_fails;
                test_idx++;
            end
        end
        if (test_idx < NUM_TESTS) begin
            $display("timed out before final checkpoint");
        end
        $display("tests ok: %0d, tests failed: %0d, check failures: %0d",
            tests_ok, NUM_TESTS - tests_ok, check_fails);
        if (check_fails == 0 && tests_ok == NUM_TESTS) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rv32_core.f ====
+incdir+sim
common/core_pkg.sv
fetch/fetch_unit.sv
logic/instruction_queue.sv
logic/register_file.sv
execute/execute_unit.sv
logic/rv32_core.sv
sim/rv32_core_tb.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --assert --timescale 1ns/1ps
TOP       := rv32_core_tb
FILELIST  := rv32_core.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
